// File: sim/commit_stim.txt
# unit uuid wid pc tmask wb rd data0 data1 data2 data3 sop eop
# unit 0 is alu, 1 is lsu, 2 is sfu; every column is hex
0 01 0 00001000 f 1 01 00000011 00000012 00000013 00000014 1 1
1 02 1 00002000 3 1 02 a0000001 a0000002 00000000 00000000 1 0
2 03 2 00003000 5 1 03 3f800000 00000000 40000000 00000000 1 1
0 04 1 00001004 7 0 00 00000000 00000000 00000000 00000000 1 1
1 05 1 00002000 c 1 02 00000000 00000000 a0000003 a0000004 0 1
0 06 3 00001008 f 1 04 deadbeef cafef00d 12345678 9abcdef0 1 1
2 07 0 00003004 f 1 05 40490fdb 402df854 3fb504f3 3f3504f3 1 1
1 08 2 00002010 1 0 00 00000000 00000000 00000000 00000000 1 1
0 09 2 0000100c e 1 06 00000000 00000111 00000222 00000333 1 1
2 0a 3 00003008 8 1 07 00000000 00000000 00000000 7f800000 1 0
2 0b 3 00003008 7 1 07 bf800000 c0000000 c0400000 00000000 0 1
0 0c 0 00001010 f 1 08 ffffffff fffffffe fffffffd fffffffc 1 1
1 0d 3 00002014 f 1 09 00010000 00020000 00030000 00040000 1 1
0 0e 1 00001014 9 0 00 00000000 00000000 00000000 00000000 1 1
1 0f 0 00002018 6 1 0a 00000000 0000beef 0000f00d 00000000 1 1
2 10 1 0000300c f 0 00 00000000 00000000 00000000 00000000 1 1
0 11 2 00001018 f 1 0b 00000001 00000002 00000004 00000008 1 0
0 12 2 0000101c f 1 0c 00000010 00000020 00000040 00000080 0 1
1 13 1 0000201c b 1 0d 11111111 22222222 00000000 44444444 1 1
2 14 2 00003010 2 1 0e 00000000 3dcccccd 00000000 00000000 1 1
0 15 3 00001020 f 1 0f 5a5a5a5a a5a5a5a5 5a5a5a5a a5a5a5a5 1 1
1 16 2 00002020 f 0 00 00000000 00000000 00000000 00000000 1 1
2 17 0 00003014 c 1 10 00000000 00000000 41200000 42c80000 1 1
0 18 0 00001024 3 1 11 0000abcd 0000dcba 00000000 00000000 1 1
1 19 3 00002024 f 1 12 87654321 0fedcba9 13579bdf 2468ace0 1 1
2 1a 1 00003018 f 1 13 00000007 00000007 00000007 00000007 1 1

// File: vlog.f
+incdir+include
verilog/commit_pkg.sv
verilog/retire_pkg.sv
verilog/commit_arb.sv
verilog/commit_buf.sv
verilog/commit_retire.sv
verilog/commit_top.sv
sim/commit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the commit stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f vlog.f --top-module commit_tb -o commit_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/commit_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi
exit 1

// File: sim/commit_tb.sv
/* commit stage testbench: stim file reader, unit drivers,
   writeback scoreboard, scheduler pulse and instret checks */
`timescale 1ns/100ps
`include "gpu_defs.svh"

module commit_tb;
    import commit_pkg::*;
    import retire_pkg::*;

    localparam int NUM_SRC    = `NUM_EX_UNITS;
    localparam int FINAL_RECS = 4;
    localparam int RESET_CYC  = 16;

    logic          clk;
    logic          reset;
    logic          alu_valid;
    commit_data_t  alu_data;
    logic          alu_ready;
    logic          lsu_valid;
    commit_data_t  lsu_data;
    logic          lsu_ready;
    logic          sfu_valid;
    commit_data_t  sfu_data;
    logic          sfu_ready;
    logic          wb_valid;
    writeback_t    wb_data;
    logic          wb_ready;
    instret_t      instret;
    commit_sched_t sched;

    // per-unit stimulus and expected writes, eop wids in transfer order
    commit_data_t         src_q [NUM_SRC][$];
    commit_data_t         exp_q [NUM_SRC][$];
    commit_data_t         file_recs [NUM_SRC][$];
    logic [`NW_WIDTH-1:0] eop_wid_q [$];
    commit_data_t         cur_data [NUM_SRC];
    logic [NUM_SRC-1:0]   cur_valid;
    int                   rec_count [NUM_SRC];
    int                   xfer_count [NUM_SRC];
    int                   mismatches;
    int                   failures;
    int                   eop_total;
    int                   pulse_count;
    int                   last_unit;
    longint               thread_sum;
    longint               limit_ns;
    logic [15:0]          lfsr_state;
    logic                 final_phase;
    logic                 loaded;

    commit_top DUT (
        .clk       (clk),
        .reset     (reset),
        .alu_valid (alu_valid),
        .alu_data  (alu_data),
        .alu_ready (alu_ready),
        .lsu_valid (lsu_valid),
        .lsu_data  (lsu_data),
        .lsu_ready (lsu_ready),
        .sfu_valid (sfu_valid),
        .sfu_data  (sfu_data),
        .sfu_ready (sfu_ready),
        .wb_valid  (wb_valid),
        .wb_data   (wb_data),
        .wb_ready  (wb_ready),
        .instret   (instret),
        .sched     (sched)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    function automatic int active_threads(input logic [`NUM_THREADS-1:0] mask);
        int n;
        n = 0;
        for (int t = 0; t < `NUM_THREADS; t++) begin
            if (mask[t]) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int sources_left();
        int n;
        n = 0;
        for (int u = 0; u < NUM_SRC; u++) begin
            n += src_q[u].size();
        end
        return n;
    endfunction

    function automatic int writes_left();
        int n;
        n = 0;
        for (int u = 0; u < NUM_SRC; u++) begin
            n += exp_q[u].size();
        end
        return n;
    endfunction

    task automatic compare_val(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_record(input int u, input commit_data_t rec);
        src_q[u].push_back(rec);
        rec_count[u]++;
        thread_sum += active_threads(rec.tmask);
        if (rec.wb) begin
            exp_q[u].push_back(rec);
        end
        if (rec.eop) begin
            eop_total++;
        end
    endtask

    task automatic load_stim();
        int           fd;
        int           n;
        int           unit;
        string        line;
        logic [31:0]  f [12];
        commit_data_t rec;
        fd = $fopen("sim/commit_stim.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("error: could not open sim/commit_stim.txt");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", unit,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11]);
                if (n == 13 && unit >= 0 && unit < NUM_SRC) begin
                    rec.uuid  = f[0][`UUID_WIDTH-1:0];
                    rec.wid   = f[1][`NW_WIDTH-1:0];
                    rec.PC    = f[2];
                    rec.tmask = f[3][`NUM_THREADS-1:0];
                    rec.wb    = f[4][0];
                    rec.rd    = f[5][`NR_BITS-1:0];
                    for (int t = 0; t < `NUM_THREADS; t++) begin
                        rec.data[t] = f[6 + t];
                    end
                    rec.sop = f[10][0];
                    rec.eop = f[11][0];
                    file_recs[unit].push_back(rec);
                    add_record(unit, rec);
                end else if (n > 0) begin
                    failures++;
                    $display("error: malformed stim line: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_wb();
        int           src;
        commit_data_t exp;
        src = -1;
        for (int u = 0; u < NUM_SRC; u++) begin
            if (src < 0 && exp_q[u].size() > 0 && exp_q[u][0].uuid == wb_data.uuid) begin
                src = u;
            end
        end
        if (src < 0) begin
            failures++;
            $display("error at %0t: writeback uuid %h is not the next write of any unit",
                     $time, wb_data.uuid);
        end else begin
            exp = exp_q[src].pop_front();
            compare_val("wb_data.wid", 32'(wb_data.wid), 32'(exp.wid));
            compare_val("wb_data.PC", wb_data.PC, exp.PC);
            compare_val("wb_data.tmask", 32'(wb_data.tmask), 32'(exp.tmask));
            compare_val("wb_data.rd", 32'(wb_data.rd), 32'(exp.rd));
            for (int t = 0; t < `NUM_THREADS; t++) begin
                compare_val($sformatf("wb_data.data[%0d]", t), wb_data.data[t], exp.data[t]);
            end
            compare_val("wb_data.sop", 32'(wb_data.sop), 32'(exp.sop));
            compare_val("wb_data.eop", 32'(wb_data.eop), 32'(exp.eop));
            // all units busy, so grants must rotate
            if (final_phase) begin
                if (last_unit >= 0) begin
                    compare_val("writeback unit", 32'(src), 32'((last_unit + 1) % NUM_SRC));
                end
                last_unit = src;
            end
        end
    endtask

    task automatic check_sched();
        logic [`NW_WIDTH-1:0] exp_wid;
        pulse_count++;
        if (eop_wid_q.size() == 0) begin
            failures++;
            $display("error at %0t: sched.committed pulsed with no eop record in flight", $time);
        end else begin
            exp_wid = eop_wid_q.pop_front();
            compare_val("sched.committed_wid", 32'(sched.committed_wid), 32'(exp_wid));
        end
    endtask

    // wb_mode 0 random, 1 held low, 2 held high
    task automatic run_cycle(input int wb_mode, input logic hold_all);
        logic               b;
        logic [NUM_SRC-1:0] ready;
        commit_data_t       rec;
        @(negedge clk);
        for (int u = 0; u < NUM_SRC; u++) begin
            if (src_q[u].size() == 0) begin
                cur_valid[u] = 1'b0;
                cur_data[u]  = '0;
            end else begin
                if (!cur_valid[u]) begin
                    if (hold_all) begin
                        cur_valid[u] = 1'b1;
                    end else begin
                        draw_bit(b);
                        cur_valid[u] = b;
                    end
                end
                cur_data[u] = src_q[u][0];
            end
        end
        alu_valid = cur_valid[0];
        alu_data  = cur_data[0];
        lsu_valid = cur_valid[1];
        lsu_data  = cur_data[1];
        sfu_valid = cur_valid[2];
        sfu_data  = cur_data[2];
        if (wb_mode == 0) begin
            draw_bit(b);
            wb_ready = b;
        end else begin
            wb_ready = (wb_mode == 2);
        end
        // sample just before the rising edge
        #3;
        ready = {sfu_ready, lsu_ready, alu_ready};
        if (sched.committed) begin
            check_sched();
        end
        if (wb_valid && wb_ready) begin
            check_wb();
        end
        for (int u = 0; u < NUM_SRC; u++) begin
            if (cur_valid[u] && ready[u]) begin
                rec = src_q[u].pop_front();
                xfer_count[u]++;
                cur_valid[u] = 1'b0;
                if (rec.eop) begin
                    eop_wid_q.push_back(rec.wid);
                end
            end
        end
    endtask

    task automatic drain();
        while (writes_left() > 0 || eop_wid_q.size() > 0) begin
            run_cycle(2, 1'b0);
        end
        // instret trails the last fire by two edges
        repeat (4) run_cycle(2, 1'b0);
    endtask

    task automatic check_totals();
        instret_t exp_ret;
        exp_ret = instret_t'(thread_sum);
        compare_val("instret", 32'(instret), 32'(exp_ret));
        compare_val("sched pulse count", 32'(pulse_count), 32'(eop_total));
        for (int u = 0; u < NUM_SRC; u++) begin
            compare_val($sformatf("transfer count of unit %0d", u), 32'(xfer_count[u]),
                        32'(rec_count[u]));
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    endtask

    initial begin
        int           cycle;
        commit_data_t rec;
        reset       = 1'b1;
        alu_valid   = 1'b0;
        alu_data    = '0;
        lsu_valid   = 1'b0;
        lsu_data    = '0;
        sfu_valid   = 1'b0;
        sfu_data    = '0;
        wb_ready    = 1'b0;
        cur_valid   = '0;
        mismatches  = 0;
        failures    = 0;
        eop_total   = 0;
        pulse_count = 0;
        last_unit   = -1;
        thread_sum  = 0;
        final_phase = 1'b0;
        loaded      = 1'b0;
        lfsr_state  = 16'd26959;
        for (int u = 0; u < NUM_SRC; u++) begin
            rec_count[u]  = 0;
            xfer_count[u] = 0;
        end
        load_stim();
        if (sources_left() == 0) begin
            failures++;
            $display("error: the stim file holds no records");
        end
        limit_ns = (longint'(sources_left() + NUM_SRC * FINAL_RECS) * 40 + RESET_CYC) * 8;
        loaded   = 1'b1;

        repeat (RESET_CYC) @(negedge clk);
        reset = 1'b0;
        #1;
        compare_val("wb_valid", 32'(wb_valid), 32'd0);
        compare_val("sched.committed", 32'(sched.committed), 32'd0);
        compare_val("instret", 32'(instret), 32'd0);

        // random traffic with a window of writeback back-pressure
        cycle = 0;
        while (sources_left() > 0) begin
            if (cycle >= 12 && cycle < 32) begin
                run_cycle(1, 1'b0);
            end else begin
                run_cycle(0, 1'b0);
            end
            cycle++;
        end
        drain();
        check_totals();

        // every unit busy, all records write back
        for (int u = 0; u < NUM_SRC; u++) begin
            for (int i = 0; i < FINAL_RECS && i < file_recs[u].size(); i++) begin
                rec    = file_recs[u][i];
                rec.wb = 1'b1;
                add_record(u, rec);
            end
        end
        final_phase = 1'b1;
        while (sources_left() > 0) begin
            run_cycle(2, 1'b1);
        end
        drain();
        final_phase = 1'b0;
        check_totals();

        report_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded === 1'b1);
        #(limit_ns);
        $display("error: run did not finish within %0d ns", limit_ns);
        report_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: verilog/commit_top.sv
/* commit stage top: arbiter, elastic buffer and retire block */
`timescale 1ns/100ps

module commit_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        alu_valid,
    input  commit_pkg::commit_data_t    alu_data,
    output logic                        alu_ready,
    input  logic                        lsu_valid,
    input  commit_pkg::commit_data_t    lsu_data,
    output logic                        lsu_ready,
    input  logic                        sfu_valid,
    input  commit_pkg::commit_data_t    sfu_data,
    output logic                        sfu_ready,
    output logic                        wb_valid,
    output commit_pkg::writeback_t      wb_data,
    input  logic                        wb_ready,
    output retire_pkg::instret_t        instret,
    output retire_pkg::commit_sched_t   sched
);
    import commit_pkg::*;

    logic         arb_valid;
    logic         arb_ready;
    commit_data_t arb_data;
    logic         buf_valid;
    logic         buf_ready;
    commit_data_t buf_data;

    commit_arb u_arb (
        .clk       (clk),
        .reset     (reset),
        .alu_valid (alu_valid),
        .alu_data  (alu_data),
        .alu_ready (alu_ready),
        .lsu_valid (lsu_valid),
        .lsu_data  (lsu_data),
        .lsu_ready (lsu_ready),
        .sfu_valid (sfu_valid),
        .sfu_data  (sfu_data),
        .sfu_ready (sfu_ready),
        .out_valid (arb_valid),
        .out_data  (arb_data),
        .out_ready (arb_ready)
    );

    // registers the arbiter choice
    commit_buf u_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (arb_valid),
        .in_data   (arb_data),
        .in_ready  (arb_ready),
        .out_valid (buf_valid),
        .out_data  (buf_data),
        .out_ready (buf_ready)
    );

    commit_retire u_retire (
        .clk      (clk),
        .reset    (reset),
        .in_valid (buf_valid),
        .in_data  (buf_data),
        .in_ready (buf_ready),
        .wb_valid (wb_valid),
        .wb_data  (wb_data),
        .wb_ready (wb_ready),
        .instret  (instret),
        .sched    (sched)
    );

endmodule

// File: verilog/commit_retire.sv
/* writeback forwarding, two-stage instret pipeline
   and eop commit notification for the warp scheduler */
`timescale 1ns/100ps
`include "gpu_defs.svh"

module commit_retire (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    input  commit_pkg::commit_data_t    in_data,
    output logic                        in_ready,
    output logic                        wb_valid,
    output commit_pkg::writeback_t      wb_data,
    input  logic                        wb_ready,
    output retire_pkg::instret_t        instret,
    output retire_pkg::commit_sched_t   sched
);
    localparam int CNT_W = $clog2(`NUM_THREADS + 1);

    logic             fire;
    logic [CNT_W-1:0] size;
    logic             fire_r;
    logic             fire_rr;
    logic [CNT_W-1:0] size_r;
    logic [CNT_W-1:0] size_rr;

    // records without a register write never wait on the port
    assign in_ready = wb_ready || !in_data.wb;
    assign fire     = in_valid && in_ready;

    assign wb_valid = in_valid && in_data.wb;
    assign wb_data  = '{
        uuid:  in_data.uuid,
        wid:   in_data.wid,
        PC:    in_data.PC,
        tmask: in_data.tmask,
        rd:    in_data.rd,
        data:  in_data.data,
        sop:   in_data.sop,
        eop:   in_data.eop
    };

    // active threads of the head record
    always_comb begin
        size = '0;
        for (int t = 0; t < `NUM_THREADS; t++) begin
            size = size + CNT_W'(in_data.tmask[t]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fire_r  <= 1'b0;
            fire_rr <= 1'b0;
        end else begin
            fire_r  <= fire;
            fire_rr <= fire_r;
        end
    end

    always_ff @(posedge clk) begin
        size_r  <= size;
        size_rr <= size_r;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instret <= '0;
        end else if (fire_rr) begin
            instret <= instret + `PERF_CTR_BITS'(size_rr);
        end
    end

    // one-cycle pulse the cycle after the eop fire
    always_ff @(posedge clk) begin
        if (reset) begin
            sched.committed <= 1'b0;
        end else begin
            sched.committed <= fire && in_data.eop;
        end
        sched.committed_wid <= in_data.wid;
    end

    a_wb_only_writes: assert property (@(posedge clk) disable iff (reset)
        $rose(wb_valid) |-> in_data.wb);

endmodule

// File: verilog/commit_buf.sv
/* two-entry valid/ready skid buffer for commit records */
`timescale 1ns/100ps

module commit_buf (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  commit_pkg::commit_data_t in_data,
    output logic                    in_ready,
    output logic                    out_valid,
    output commit_pkg::commit_data_t out_data,
    input  logic                    out_ready
);
    import commit_pkg::*;

    logic         main_valid;
    logic         spare_valid;
    commit_data_t main_data;
    commit_data_t spare_data;
    logic         push;
    logic         load_main;

    // ready only depends on registered state
    assign in_ready  = !spare_valid;
    assign push      = in_valid && in_ready;
    // main slot empty or being drained this cycle
    assign load_main = !main_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else if (load_main) begin
            main_valid  <= spare_valid || push;
            spare_valid <= 1'b0;
        end else if (push) begin
            spare_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_main) begin
            main_data <= spare_valid ? spare_data : in_data;
        end
        // stalled output, park the new record
        if (!load_main && push) begin
            spare_data <= in_data;
        end
    end

    assign out_valid = main_valid;
    assign out_data  = main_data;

    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        main_valid && spare_valid |-> !(in_valid && in_ready));

endmodule

// File: verilog/commit_arb.sv
/* round-robin arbiter over the alu, lsu and sfu commit streams */
`timescale 1ns/100ps
`include "gpu_defs.svh"

module commit_arb (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    alu_valid,
    input  commit_pkg::commit_data_t alu_data,
    output logic                    alu_ready,
    input  logic                    lsu_valid,
    input  commit_pkg::commit_data_t lsu_data,
    output logic                    lsu_ready,
    input  logic                    sfu_valid,
    input  commit_pkg::commit_data_t sfu_data,
    output logic                    sfu_ready,
    output logic                    out_valid,
    output commit_pkg::commit_data_t out_data,
    input  logic                    out_ready
);
    import commit_pkg::*;

    localparam int NUM_SRC = `NUM_EX_UNITS;
    localparam int PTR_W   = $clog2(NUM_SRC);

    logic [NUM_SRC-1:0] src_valid;
    commit_data_t       src_data [NUM_SRC];
    logic [NUM_SRC-1:0] grant;
    logic [PTR_W-1:0]   grant_idx;
    logic [PTR_W-1:0]   ptr;

    // source 0 is alu, then lsu, then sfu
    assign src_valid   = {sfu_valid, lsu_valid, alu_valid};
    assign src_data[0] = alu_data;
    assign src_data[1] = lsu_data;
    assign src_data[2] = sfu_data;

    // first valid source at or after the pointer
    always_comb begin
        int unsigned idx;
        logic        found;
        grant     = '0;
        grant_idx = ptr;
        found     = 1'b0;
        for (int k = 0; k < NUM_SRC; k++) begin
            idx = int'(ptr) + k;
            if (idx >= NUM_SRC) begin
                idx = idx - NUM_SRC;
            end
            if (!found && src_valid[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                grant_idx  = PTR_W'(idx);
            end
        end
    end

    assign out_valid = |src_valid;
    assign out_data  = src_data[grant_idx];

    assign alu_ready = out_ready && grant[0];
    assign lsu_ready = out_ready && grant[1];
    assign sfu_ready = out_ready && grant[2];

    // rotate past the winner after each transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (out_valid && out_ready) begin
            ptr <= (grant_idx == PTR_W'(NUM_SRC - 1)) ? '0 : grant_idx + 1'b1;
        end
    end

    a_single_ready: assert property (@(posedge clk) disable iff (reset)
        $onehot0({alu_ready, lsu_ready, sfu_ready}));

endmodule

// File: verilog/retire_pkg.sv
/* retire side types: instret counter and
   warp scheduler commit notification */
`include "gpu_defs.svh"

package retire_pkg;

    // retired thread-instruction count
    typedef logic [`PERF_CTR_BITS-1:0] instret_t;

    // last micro-op of a warp instruction has committed
    typedef struct packed {
        logic                   committed;
        logic [`NW_WIDTH-1:0]   committed_wid;
    } commit_sched_t;

endpackage

// File: verilog/commit_pkg.sv
/* commit record from the execution units and
   writeback record toward the register file */
`include "gpu_defs.svh"

package commit_pkg;

    // finished result presented by an execution unit
    typedef struct packed {
        logic [`UUID_WIDTH-1:0]                 uuid;
        logic [`NW_WIDTH-1:0]                   wid;
        logic [`XLEN-1:0]                       PC;
        logic [`NUM_THREADS-1:0]                tmask;
        logic                                   wb;
        logic [`NR_BITS-1:0]                    rd;
        logic [`NUM_THREADS-1:0][`XLEN-1:0]     data;
        logic                                   sop;
        logic                                   eop;
    } commit_data_t;

    // register file write, no wb flag since it is always a write
    typedef struct packed {
        logic [`UUID_WIDTH-1:0]                 uuid;
        logic [`NW_WIDTH-1:0]                   wid;
        logic [`XLEN-1:0]                       PC;
        logic [`NUM_THREADS-1:0]                tmask;
        logic [`NR_BITS-1:0]                    rd;
        logic [`NUM_THREADS-1:0][`XLEN-1:0]     data;
        logic                                   sop;
        logic                                   eop;
    } writeback_t;

endpackage

// File: include/gpu_defs.svh
/* core dimension macros for the commit stage:
   warp and thread counts, field widths and number of commit sources */
`ifndef GPU_DEFS_SVH
`define GPU_DEFS_SVH

// threads per warp, also the tmask width
`define NUM_THREADS 4

// width of one thread result
`define XLEN 32

// warps and warp id width
`define NUM_WARPS 4
`define NW_WIDTH 2

// register index width
`define NR_BITS 5

// instruction tag width
`define UUID_WIDTH 8

// instret counter width
`define PERF_CTR_BITS 16

// alu, lsu and sfu
`define NUM_EX_UNITS 3

`endif
